// ==== src.f ====
+incdir+include
hw/motor_pkg.sv
hw/quad_decoder.sv
hw/speed_meter.sv
hw/motor_control.sv
hw/motor_board_top.sv
testbench/encoder_model.sv
testbench/tb_motor_board.sv

// ==== Makefile ====
# Verilator build and run of the motor speed controller testbench
TOP = tb_motor_board

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

# Pass is decided by the message in the simulation output
run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== testbench/tb_motor_board.sv ====
//============================================================
// Testbench for the motor speed controller board top
// Each setting is measured three windows after it changes
// Step periods must divide MC_WINDOW for exact speed
//============================================================
`timescale 1ns/1ps
`include "motor_consts.svh"

module tb_motor_board import motor_pkg::*; ();

  localparam int NUM_SETTINGS = 14;
  localparam int MAX_CYCLES   = NUM_SETTINGS * 4 * `MC_WINDOW + 1000;
  localparam int PERIODS [3]  = '{8, 16, 32};

  // Active low digits in {g,f,e,d,c,b,a} order
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  logic clk, rst_n;
  logic [2:0] button;
  logic [9:0] sw;
  logic enc_run, enc_fwd;
  logic [15:0] enc_period;
  logic enc_a, enc_b;
  seg_t hex0_d, hex1_d, hex2_d, hex3_d;
  logic hex0_dp, hex1_dp, hex2_dp, hex3_dp;
  logic [9:0] ledg;
  logic [1:0] motor_in;
  logic motor_en;

  integer     seed = 60755;
  int         cycle_cnt = 0;
  int         req_id = 0;    // Raised by stimulus per setting
  int         done_id = 0;   // Follows req_id once measured
  int         exp_duty;
  drive_dir_e exp_dir;

  motor_board_top motor_board_top_i (
    .clk(clk), .rst_n(rst_n), .button(button), .sw(sw),
    .enc_a(enc_a), .enc_b(enc_b),
    .hex0_d(hex0_d), .hex0_dp(hex0_dp), .hex1_d(hex1_d), .hex1_dp(hex1_dp),
    .hex2_d(hex2_d), .hex2_dp(hex2_dp), .hex3_d(hex3_d), .hex3_dp(hex3_dp),
    .ledg(ledg), .motor_in(motor_in), .motor_en(motor_en)
  );

  encoder_model encoder_model_i (
    .clk(clk), .rst_n(rst_n), .run(enc_run), .dir_fwd(enc_fwd),
    .period(enc_period), .enc_a(enc_a), .enc_b(enc_b)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  //==========================================================
  // Reference model and check
  //==========================================================
  function automatic void ref_control(input int setpoint, input int gain,
                                      input int period, input bit fwd,
                                      output int duty, output drive_dir_e dir);
    int speed;
    int drive;
    speed = 0;                                    // Still shaft
    if (period != 0)
      speed = fwd ? (`MC_WINDOW / period) : -(`MC_WINDOW / period);
    drive = (gain * (setpoint - speed)) >>> `MC_GAIN_SHIFT;  // Floor
    duty  = (drive < 0) ? -drive : drive;
    if (duty > `MC_DUTY_MAX)
      duty = `MC_DUTY_MAX;
    if (drive > 0)
      dir = DRIVE_FWD;
    else if (drive < 0)
      dir = DRIVE_REV;
    else
      dir = DRIVE_BRAKE;
  endfunction

  task automatic check_value(input string what, input int actual, input int expected);
    if (actual != expected) begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Display outputs follow the inputs combinationally
  task automatic check_display(input bit up_btn, input bit down_btn, input bit en,
                               input int gain_val);
    check_value("ledg gain", int'(ledg[9:2]), gain_val & 255);
    check_value("ledg buttons", int'(ledg[1:0]), int'({down_btn, up_btn}));
    check_value("hex1_d", int'(hex1_d), int'(SEG_TABLE[gain_val[3:0]]));
    check_value("hex2_d", int'(hex2_d), int'(SEG_TABLE[gain_val[7:4]]));
    check_value("hex3_d", int'(hex3_d), 'h7f);    // Dark
    check_value("hex0_d", int'(hex0_d), en ? 0 : 'h7f);
    check_value("hex0_dp", int'(hex0_dp), en ? 1 : 0);
    check_value("hex dps", int'({hex1_dp, hex2_dp, hex3_dp}), 7);
  endtask

  //==========================================================
  // Stimulus
  //==========================================================
  task automatic apply_setting(input bit up_btn, input bit down_btn, input bit en,
                               input int gain_val, input int period, input bit fwd);
    int setpoint;
    setpoint = 0;                         // None or both buttons
    if (up_btn && !down_btn)
      setpoint = `MC_TARGET_SPEED;
    else if (down_btn && !up_btn)
      setpoint = -`MC_TARGET_SPEED;
    @(posedge clk);
    button     <= {1'b1, ~down_btn, ~up_btn};
    sw         <= {gain_val[7:0], 1'b0, en};
    enc_run    <= (period != 0);
    enc_period <= 16'(period);
    enc_fwd    <= fwd;
    ref_control(setpoint, gain_val & 255, period, fwd, exp_duty, exp_dir);
    if (!en) begin
      exp_duty = 0;                       // Bridge off
      exp_dir  = DRIVE_BRAKE;
    end
    @(negedge clk);
    check_display(up_btn, down_btn, en, gain_val);
    req_id++;
    wait (done_id == req_id);             // Measurement finished
  endtask

  initial begin : stimulus
    int gain_val;
    int run_gains [3];
    rst_n      = 1'b0;
    button     = 3'b111;                  // Nothing pressed
    sw         = 10'd0;
    enc_run    = 1'b0;
    enc_fwd    = 1'b1;
    enc_period = 16'd0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("motor_en after reset", int'(motor_en), 0);
    check_value("motor_in after reset", int'(motor_in), int'(DRIVE_BRAKE));

    // Idle and enabled
    gain_val = $random(seed) & 255;
    apply_setting(1'b0, 1'b0, 1'b1, gain_val, 0, 1'b1);

    // Up held with the shaft still
    apply_setting(1'b1, 1'b0, 1'b1, 255, 0, 1'b1);
    repeat (3) begin
      gain_val = $random(seed) & 255;
      apply_setting(1'b1, 1'b0, 1'b1, gain_val, 0, 1'b1);
    end

    // Up held with forward motion
    for (int i = 0; i < 3; i++) begin
      run_gains[i] = $random(seed) & 255;
      apply_setting(1'b1, 1'b0, 1'b1, run_gains[i], PERIODS[i], 1'b1);
    end
    apply_setting(1'b1, 1'b0, 1'b1, 200, 8, 1'b0);   // Large error clamps

    // Down held with reverse motion and the same gains
    for (int i = 0; i < 3; i++)
      apply_setting(1'b0, 1'b1, 1'b1, run_gains[i], PERIODS[i], 1'b0);

    // Enable off and then both buttons
    gain_val = $random(seed) & 255;
    apply_setting(1'b1, 1'b0, 1'b0, gain_val, 0, 1'b1);
    gain_val = $random(seed) & 255;
    apply_setting(1'b1, 1'b1, 1'b1, gain_val, 16, 1'b1);

    $display("All tests passed");
    $finish;
  end

  //==========================================================
  // Measurement process
  //==========================================================
  initial begin : compare_proc
    int high_cnt;
    forever begin
      wait (req_id != done_id);
      repeat (3 * `MC_WINDOW) @(negedge clk);   // Settle speed and duty
      high_cnt = 0;
      repeat (`MC_PWM_PERIOD) begin
        @(negedge clk);
        if (motor_en)
          high_cnt++;
        check_value("motor_in", int'(motor_in), int'(exp_dir));
      end
      check_value("duty", high_cnt, exp_duty);
      done_id = req_id;
    end
  end

  // Run length limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Some tests failed");
      $fatal(1, "timeout");
    end
  end

endmodule

// ==== testbench/encoder_model.sv ====
//============================================================
// Quadrature encoder model for the testbench
// One step every period clk cycles while run is high
// period must be nonzero, a period of 0 holds the shaft
// Outputs change only after a rising clk edge
//============================================================
`timescale 1ns/1ps

module encoder_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        run,       // Shaft turns when high
  input  logic        dir_fwd,   // 1 = forward sequence
  input  logic [15:0] period,    // clk cycles per step
  output logic        enc_a,
  output logic        enc_b
);

  logic [1:0]  pos;        // Shaft position, 4 states per cycle
  logic [15:0] tick_cnt;   // Cycles since the last step

  //==========================================================
  // Step timing
  //==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos      <= 2'd0;
      tick_cnt <= '0;
    end else if (!run || (period == 16'd0)) begin
      tick_cnt <= '0;                  // Shaft held
    end else if (tick_cnt >= (period - 16'd1)) begin
      tick_cnt <= '0;                  // Also catches a shortened period
      if (dir_fwd)
        pos <= pos + 2'd1;
      else
        pos <= pos - 2'd1;
    end else begin
      tick_cnt <= tick_cnt + 16'd1;
    end
  end

  // Forward order A,B = 00, 10, 11, 01
  always_comb begin
    case (pos)
      2'd0:    {enc_a, enc_b} = 2'b00;
      2'd1:    {enc_a, enc_b} = 2'b10;
      2'd2:    {enc_a, enc_b} = 2'b11;
      default: {enc_a, enc_b} = 2'b01;
    endcase
  end

endmodule

// ==== hw/motor_board_top.sv ====
//============================================================
// Motor speed controller board top level
// Buttons are active low, segments and DPs active low
// Encoder and bridge are plain pins, no GPIO tri-states
// button[2] and sw[1] are not used
//============================================================
`timescale 1ns/1ps

module motor_board_top import motor_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [2:0] button,     // Push buttons, active low
  input  logic [9:0] sw,         // Toggle switches
  input  logic       enc_a,      // Encoder channel A
  input  logic       enc_b,      // Encoder channel B
  output seg_t       hex0_d,     // Enable indicator digit
  output logic       hex0_dp,
  output seg_t       hex1_d,     // Gain low nibble
  output logic       hex1_dp,
  output seg_t       hex2_d,     // Gain high nibble
  output logic       hex2_dp,
  output seg_t       hex3_d,     // Unused digit
  output logic       hex3_dp,
  output logic [9:0] ledg,       // Green LEDs
  output logic [1:0] motor_in,   // H-bridge direction pair
  output logic       motor_en    // H-bridge enable, PWM
);

  //==========================================================
  // Internal signals
  //==========================================================
  logic       up, down;        // Pressed buttons, active high
  logic       enable;          // Motor enable switch
  gain_t      gain;            // Gain from switches
  logic       step;            // Decoder step pulse
  logic       step_dir;
  speed_t     speed;           // Measured speed
  logic       speed_valid;
  drive_dir_e motor_dir;       // Controller direction output

  //==========================================================
  // Inputs
  //==========================================================
  assign up     = ~button[0];  // Forward request
  assign down   = ~button[1];  // Reverse request
  assign enable = sw[0];
  assign gain   = sw[9:2];

  //==========================================================
  // Display
  //==========================================================
  assign ledg[1:0] = {down, up};  // Pressed buttons
  assign ledg[9:2] = gain;        // Gain in binary

  // All segments lit when enabled, only the DP when disabled
  assign hex0_d  = {$bits(seg_t){~enable}};
  assign hex0_dp = enable;

  assign hex1_d  = hex_to_seg(gain[3:0]);
  assign hex2_d  = hex_to_seg(gain[7:4]);
  assign hex3_d  = '1;       // Dark
  assign hex1_dp = 1'b1;
  assign hex2_dp = 1'b1;
  assign hex3_dp = 1'b1;

  //==========================================================
  // Encoder to bridge chain
  //==========================================================
  quad_decoder quad_decoder_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .enc_a    (enc_a),
    .enc_b    (enc_b),
    .step     (step),
    .step_dir (step_dir)
  );

  speed_meter speed_meter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .step        (step),
    .step_dir    (step_dir),
    .speed       (speed),
    .speed_valid (speed_valid)
  );

  motor_control motor_control_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .up           (up),
    .down         (down),
    .motor_enable (enable),
    .gain         (gain),
    .speed        (speed),
    .speed_valid  (speed_valid),
    .motor_in     (motor_dir),
    .motor_en     (motor_en)
  );

  assign motor_in = motor_dir;  // Enum encodes the pin pair

endmodule

// ==== hw/motor_control.sv ====
//============================================================
// Proportional speed controller with PWM output
// Duty and direction update one clk after speed_valid
// No integral or derivative term, no fault handling
// Bridge must accept motor_in/motor_en every cycle
//============================================================
`timescale 1ns/1ps
`include "motor_consts.svh"

module motor_control import motor_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       up,            // Request forward setpoint
  input  logic       down,          // Request reverse setpoint
  input  logic       motor_enable,  // Enable switch
  input  gain_t      gain,          // Proportional gain
  input  speed_t     speed,         // Measured speed
  input  logic       speed_valid,   // New measurement this cycle
  output drive_dir_e motor_in,      // H-bridge direction pair
  output logic       motor_en       // H-bridge PWM enable
);

  localparam int ERR_W  = `MC_SPEED_W + 1;              // setpoint - speed
  localparam int PROD_W = ERR_W + $bits(gain_t) + 1;    // Signed product
  localparam int PWM_W  = $clog2(`MC_PWM_PERIOD);

  speed_t                    setpoint;
  logic signed [ERR_W-1:0]   err;
  logic signed [PROD_W-1:0]  prod;
  logic signed [PROD_W-1:0]  drive;   // Scaled error
  logic [PROD_W-1:0]         mag;     // |drive|
  duty_t                     duty_next;
  drive_dir_e                dir_next;
  duty_t                     duty;    // Held between updates
  drive_dir_e                dir;
  logic [PWM_W-1:0]          pwm_cnt;

  //==========================================================
  // Proportional law
  //==========================================================
  always_comb begin
    if (up && !down)
      setpoint = speed_t'(`MC_TARGET_SPEED);
    else if (down && !up)
      setpoint = speed_t'(-`MC_TARGET_SPEED);
    else
      setpoint = '0;  // None or both buttons
  end

  assign err   = ERR_W'(setpoint) - ERR_W'(speed);                // Sign extended
  assign prod  = PROD_W'(err) * PROD_W'($signed({1'b0, gain}));   // Gain as positive
  assign drive = prod >>> `MC_GAIN_SHIFT;                         // Rounds toward -inf

  assign mag = drive[PROD_W-1] ? $unsigned(-drive) : $unsigned(drive);

  // Clamp magnitude to the duty range
  assign duty_next = (mag > PROD_W'(`MC_DUTY_MAX)) ? duty_t'(`MC_DUTY_MAX)
                                                  : duty_t'(mag);

  always_comb begin
    if (drive == '0)
      dir_next = DRIVE_BRAKE;
    else if (drive[PROD_W-1])
      dir_next = DRIVE_REV;
    else
      dir_next = DRIVE_FWD;
  end

  // Update only on a fresh measurement
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duty <= '0;
      dir  <= DRIVE_BRAKE;
    end else if (speed_valid) begin
      duty <= duty_next;
      dir  <= dir_next;
    end
  end

  //==========================================================
  // PWM generation
  //==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      pwm_cnt <= '0;
    else if (pwm_cnt == PWM_W'(`MC_PWM_PERIOD - 1))
      pwm_cnt <= '0;  // Wrap at period end
    else
      pwm_cnt <= pwm_cnt + 1'b1;
  end

  // duty high cycles in every period
  assign motor_en = motor_enable && (pwm_cnt < duty);
  assign motor_in = motor_enable ? dir : DRIVE_BRAKE;

  // Zero drive clamps to zero duty, so brake never sees a pulse
  en_not_brake_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    motor_en |-> (motor_in != DRIVE_BRAKE)
  ) else $error("motor_control: PWM enable active while braking");

endmodule

// ==== hw/speed_meter.sv ====
//============================================================
// Encoder speed meter
// Counts signed steps over each MC_WINDOW-cycle window
// speed updates at window end, speed_valid pulses once
// First window after reset starts on the first clk
//============================================================
`timescale 1ns/1ps
`include "motor_consts.svh"

module speed_meter import motor_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   step,         // From quad_decoder
  input  logic   step_dir,     // 1 = forward
  output speed_t speed,        // Steps in last full window
  output logic   speed_valid   // Pulse when speed is updated
);

  localparam int WIN_W = $clog2(`MC_WINDOW);

  logic [WIN_W-1:0] win_cnt;   // Position inside window
  logic             win_last;  // Last cycle of window
  speed_t           acc;       // Running step count
  speed_t           delta;     // Contribution of this cycle

  assign win_last = (win_cnt == WIN_W'(`MC_WINDOW - 1));

  always_comb begin
    if (!step)
      delta = '0;
    else if (step_dir)
      delta = speed_t'(1);
    else
      delta = speed_t'(-1);
  end

  //==========================================================
  // Window counter and accumulator
  //==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_cnt     <= '0;
      acc         <= '0;
      speed       <= '0;
      speed_valid <= 1'b0;
    end else begin
      speed_valid <= win_last;
      if (win_last) begin
        win_cnt <= '0;
        speed   <= acc;    // Publish, this cycle's step not included
        acc     <= delta;  // ...it opens the next window instead
      end else begin
        win_cnt <= win_cnt + 1'b1;
        acc     <= acc + delta;
      end
    end
  end

  // At most one step per cycle, so count stays within a window
  acc_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (acc <= speed_t'(`MC_WINDOW)) && (acc >= speed_t'(-`MC_WINDOW))
  ) else $error("speed_meter: step accumulator out of range");

endmodule

// ==== hw/quad_decoder.sv ====
//============================================================
// Quadrature encoder decoder
// enc_a/enc_b are asynchronous, two-flop synchronized
// Step pulse trails a pin change by 3 clk cycles
// Double-bit changes give no step and fire an assertion
//============================================================
`timescale 1ns/1ps

module quad_decoder (
  input  logic clk,
  input  logic rst_n,
  input  logic enc_a,     // Encoder channel A, async
  input  logic enc_b,     // Encoder channel B, async
  output logic step,      // One-cycle pulse per legal edge
  output logic step_dir   // 1 = forward
);

  logic a_meta, b_meta;   // First sync stage
  logic a_sync, b_sync;   // Second sync stage
  logic a_prev, b_prev;   // Last decoded pair
  logic [1:0] pos_cur;    // Position in the 4-state cycle
  logic [1:0] pos_prev;
  logic [1:0] pos_diff;

  //==========================================================
  // Synchronizer
  //==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_meta <= 1'b0;
      b_meta <= 1'b0;
      a_sync <= 1'b0;
      b_sync <= 1'b0;
    end else begin
      a_meta <= enc_a;
      b_meta <= enc_b;
      a_sync <= a_meta;
      b_sync <= b_meta;
    end
  end

  // Forward order 00,10,11,01 maps to positions 0..3
  assign pos_cur  = {b_sync, a_sync ^ b_sync};
  assign pos_prev = {b_prev, a_prev ^ b_prev};
  assign pos_diff = pos_cur - pos_prev;  // 1 fwd, 3 rev, 2 illegal

  //==========================================================
  // Edge decode
  //==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_prev   <= 1'b0;
      b_prev   <= 1'b0;
      step     <= 1'b0;
      step_dir <= 1'b0;
    end else begin
      a_prev   <= a_sync;
      b_prev   <= b_sync;
      step     <= (pos_diff == 2'd1) || (pos_diff == 2'd3);
      step_dir <= (pos_diff == 2'd1);  // Only meaningful with step
    end
  end

  // Encoder must never move both channels between two samples
  double_change_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    !((a_sync != a_prev) && (b_sync != b_prev))
  ) else $error("quad_decoder: illegal double-bit encoder transition");

endmodule

// ==== hw/motor_pkg.sv ====
//============================================================
// Shared types for the motor speed controller
// Widths come from motor_consts.svh
// Segment patterns are active low, bit 6 is segment g
//============================================================
`include "motor_consts.svh"

package motor_pkg;

  typedef logic signed [`MC_SPEED_W-1:0] speed_t;  // Steps per window
  typedef logic [`MC_GAIN_W-1:0]         gain_t;   // Unsigned P gain
  typedef logic [`MC_DUTY_W-1:0]         duty_t;   // High cycles per period
  typedef logic [`MC_SEG_W-1:0]          seg_t;    // Active low digit

  // Values match the H-bridge input pair directly
  typedef enum logic [1:0] {
    DRIVE_BRAKE = 2'b00,  // Both low, motor coasts/brakes
    DRIVE_FWD   = 2'b10,
    DRIVE_REV   = 2'b01
  } drive_dir_e;

  //==========================================================
  // Hex digit decode
  //==========================================================
  function automatic seg_t hex_to_seg(input logic [3:0] value);
    seg_t seg;
    case (value)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'ha: seg = 7'b0001000;
      4'hb: seg = 7'b0000011;  // Lower case b
      4'hc: seg = 7'b1000110;
      4'hd: seg = 7'b0100001;  // Lower case d
      4'he: seg = 7'b0000110;
      default: seg = 7'b0001110;  // F
    endcase
    return seg;
  endfunction

endpackage

// ==== include/motor_consts.svh ====
//============================================================
// Motor speed controller constants
// Window and PWM period assume one clk per count
// MC_WINDOW and MC_PWM_PERIOD need not be powers of two
//============================================================
`ifndef MOTOR_CONSTS_SVH
`define MOTOR_CONSTS_SVH

// Speed measurement
`define MC_WINDOW        256   // Sample window, clk cycles
`define MC_SPEED_W       10    // Signed steps per window

// Control law
`define MC_TARGET_SPEED  16    // Setpoint magnitude, steps per window
`define MC_GAIN_SHIFT    4     // Right shift after gain multiply
`define MC_GAIN_W        8     // Gain from switches

// PWM output
`define MC_PWM_PERIOD    256   // PWM period, clk cycles
`define MC_DUTY_MAX      255   // Clamp for duty
`define MC_DUTY_W        8

// Display
`define MC_SEG_W         7     // Active low, {g,f,e,d,c,b,a}

`endif
